// ==== adc_settings.svh ====
`ifndef ADC_SETTINGS_SVH
`define ADC_SETTINGS_SVH

// Width of one signed ADC sample
`define ADC_DATA_WIDTH 16

// Largest decimation exponent, ratios run from 1 to 16
`define ADC_MAX_DEC_SHIFT 4

// Sample FIFO entries, and the decimator's initial credit count
`define ADC_FIFO_DEPTH 8

// Fractional bits of the calibration gain (Q4.12, 1.0 is 4096)
`define ADC_GAIN_FRAC 12

`endif

// ==== adc_pkg.sv ====
`default_nettype none

`include "adc_settings.svh"

package adc_pkg;

    // Raw and calibrated samples share one signed format
    typedef logic signed [`ADC_DATA_WIDTH-1:0] sample_t;

    // Block sum of up to 2^ADC_MAX_DEC_SHIFT samples, wide enough to never wrap
    typedef logic signed [`ADC_DATA_WIDTH+`ADC_MAX_DEC_SHIFT-1:0] acc_t;

    // Unsigned Q4.12 gain
    typedef logic [15:0] gain_t;

    // Decimation exponent, valid range is 0 to ADC_MAX_DEC_SHIFT
    typedef logic [2:0] shift_t;

endpackage

`default_nettype wire

// ==== adc_decimator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_settings.svh"

module adc_decimator import adc_pkg::*; (
    input  wire     clock,
    input  wire     rst,
    input  sample_t in_data,
    input  wire     in_valid,
    input  shift_t  dec_shift,
    input  wire     credit_return,
    output logic    push,
    output sample_t push_data,
    output logic    overrun
);

    localparam int COUNT_W  = `ADC_MAX_DEC_SHIFT;
    localparam int CREDIT_W = $clog2(`ADC_FIFO_DEPTH + 1);

    logic [COUNT_W-1:0]  sample_count;
    logic [COUNT_W:0]    block_last;
    logic [CREDIT_W-1:0] credits;
    acc_t                acc;
    acc_t                acc_sum;
    acc_t                acc_avg;
    logic                block_done;
    logic                take;

    // Index of the final sample in a block, one extra bit so 2^4 fits
    assign block_last = ({{COUNT_W{1'b0}}, 1'b1} << dec_shift) - 1'b1;

    // The first sample of a block starts a fresh sum
    always_comb begin
        if (sample_count == '0) begin
            acc_sum = acc_t'(in_data);
        end else begin
            acc_sum = acc + acc_t'(in_data);
        end
        acc_avg = acc_sum >>> dec_shift;
    end

    assign block_done = in_valid && (sample_count == block_last[COUNT_W-1:0]);

    // A block only goes to the FIFO when a credit is held at the moment it completes
    assign take = block_done && (credits != '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            sample_count <= '0;
        end else if (in_valid) begin
            if (block_done) begin
                sample_count <= '0;
            end else begin
                sample_count <= sample_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            acc <= acc_sum;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            credits <= CREDIT_W'(`ADC_FIFO_DEPTH);
        end else begin
            case ({take, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            push    <= 1'b0;
            overrun <= 1'b0;
        end else begin
            push <= take;
            // Sticky, a dropped block is never forgotten until reset
            if (block_done && (credits == '0)) begin
                overrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            push_data <= acc_avg[`ADC_DATA_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_settings.svh"

module sample_fifo import adc_pkg::*; (
    input  wire     clock,
    input  wire     rst,
    input  wire     push,
    input  sample_t push_data,
    input  wire     pop,
    output logic    fifo_valid,
    output sample_t fifo_data,
    output logic    credit_return
);

    localparam int DEPTH   = `ADC_FIFO_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int COUNT_W = $clog2(DEPTH + 1);

    sample_t            mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               do_pop;

    assign do_pop = pop && fifo_valid;

    // The head entry is read straight out of its storage register
    assign fifo_valid = (count != '0);
    assign fifo_data  = mem[rd_ptr];

    // No full check here, the decimator never pushes without a credit
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit goes back to the decimator for every entry handed on
            credit_return <= do_pop;
        end
    end

endmodule

`default_nettype wire

// ==== adc_calibrator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_settings.svh"

module adc_calibrator import adc_pkg::*; (
    input  wire     clock,
    input  wire     rst,
    input  wire     fifo_valid,
    input  sample_t fifo_data,
    output logic    pop,
    input  sample_t cal_offset,
    input  gain_t   cal_gain,
    output logic    out_valid,
    output sample_t out_data,
    input  wire     out_ready
);

    localparam int DIFF_W = `ADC_DATA_WIDTH + 1;
    localparam int PROD_W = DIFF_W + $bits(gain_t) + 1;

    // Limits of sample_t, held at product width for the saturation compare
    localparam logic signed [PROD_W-1:0] SAT_MAX =
        {{(PROD_W - `ADC_DATA_WIDTH + 1){1'b0}}, {(`ADC_DATA_WIDTH - 1){1'b1}}};
    localparam logic signed [PROD_W-1:0] SAT_MIN =
        {{(PROD_W - `ADC_DATA_WIDTH + 1){1'b1}}, {(`ADC_DATA_WIDTH - 1){1'b0}}};

    logic signed [DIFF_W-1:0] diff;
    logic signed [DIFF_W-1:0] s1_data;
    logic                     s1_valid;
    logic                     s1_ready;
    logic                     s2_ready;
    logic signed [PROD_W-1:0] product;
    logic signed [PROD_W-1:0] scaled;
    sample_t                  sat_data;

    // A stage moves on when the one after it is empty or being emptied
    assign s2_ready = !out_valid || out_ready;
    assign s1_ready = !s1_valid || s2_ready;
    assign pop      = fifo_valid && s1_ready;

    // One extra bit keeps the offset subtraction from wrapping
    assign diff = fifo_data - cal_offset;

    always_comb begin
        product = s1_data * $signed({1'b0, cal_gain});
        scaled  = product >>> `ADC_GAIN_FRAC;
        if (scaled > SAT_MAX) begin
            sat_data = SAT_MAX[`ADC_DATA_WIDTH-1:0];
        end else if (scaled < SAT_MIN) begin
            sat_data = SAT_MIN[`ADC_DATA_WIDTH-1:0];
        end else begin
            sat_data = scaled[`ADC_DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= fifo_valid;
            end
            if (s2_ready) begin
                out_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            s1_data <= diff;
        end
        // Output data stays put while the sink holds off
        if (s1_valid && s2_ready) begin
            out_data <= sat_data;
        end
    end

endmodule

`default_nettype wire

// ==== window_comparator.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_comparator import adc_pkg::*; (
    input  wire     clock,
    input  wire     rst,
    input  wire     sample_valid,
    input  sample_t sample,
    input  sample_t threshold_high,
    input  sample_t threshold_low,
    input  wire     latch_mode,
    input  wire     clear_trips,
    output logic    trip_high,
    output logic    trip_low
);

    logic above;
    logic below;

    // Both limits are exclusive, a sample equal to a threshold does not trip
    assign above = (sample > threshold_high);
    assign below = (sample < threshold_low);

    always_ff @(posedge clock) begin
        if (rst) begin
            trip_high <= 1'b0;
            trip_low  <= 1'b0;
        end else if (clear_trips) begin
            trip_high <= 1'b0;
            trip_low  <= 1'b0;
        end else if (sample_valid) begin
            if (latch_mode) begin
                // Latched flags only ever set here
                trip_high <= trip_high || above;
                trip_low  <= trip_low || below;
            end else begin
                trip_high <= above;
                trip_low  <= below;
            end
        end
    end

endmodule

`default_nettype wire

// ==== adc_processing.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_processing import adc_pkg::*; (
    input  wire     clock,
    input  wire     rst,
    input  sample_t in_data,
    input  wire     in_valid,
    input  shift_t  dec_shift,
    input  sample_t cal_offset,
    input  gain_t   cal_gain,
    input  sample_t fast_high,
    input  sample_t fast_low,
    input  sample_t slow_high,
    input  sample_t slow_low,
    input  wire     latch_mode,
    input  wire     clear_trips,
    output logic    out_valid,
    output sample_t out_data,
    input  wire     out_ready,
    output logic    overrun,
    output logic    fast_trip_high,
    output logic    fast_trip_low,
    output logic    slow_trip_high,
    output logic    slow_trip_low
);

    logic    push;
    sample_t push_data;
    logic    credit_return;
    logic    fifo_valid;
    sample_t fifo_data;
    logic    pop;
    logic    out_fire;

    // The slow comparator sees each calibrated sample as it leaves
    assign out_fire = out_valid && out_ready;

    adc_decimator dec (
        .clock(clock),
        .rst(rst),
        .in_data(in_data),
        .in_valid(in_valid),
        .dec_shift(dec_shift),
        .credit_return(credit_return),
        .push(push),
        .push_data(push_data),
        .overrun(overrun)
    );

    sample_fifo fifo (
        .clock(clock),
        .rst(rst),
        .push(push),
        .push_data(push_data),
        .pop(pop),
        .fifo_valid(fifo_valid),
        .fifo_data(fifo_data),
        .credit_return(credit_return)
    );

    adc_calibrator calibrator (
        .clock(clock),
        .rst(rst),
        .fifo_valid(fifo_valid),
        .fifo_data(fifo_data),
        .pop(pop),
        .cal_offset(cal_offset),
        .cal_gain(cal_gain),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_ready(out_ready)
    );

    // Raw stream, checked on every ADC sample
    window_comparator fast_cmp (
        .clock(clock),
        .rst(rst),
        .sample_valid(in_valid),
        .sample(in_data),
        .threshold_high(fast_high),
        .threshold_low(fast_low),
        .latch_mode(latch_mode),
        .clear_trips(clear_trips),
        .trip_high(fast_trip_high),
        .trip_low(fast_trip_low)
    );

    window_comparator slow_cmp (
        .clock(clock),
        .rst(rst),
        .sample_valid(out_fire),
        .sample(out_data),
        .threshold_high(slow_high),
        .threshold_low(slow_low),
        .latch_mode(latch_mode),
        .clear_trips(clear_trips),
        .trip_high(slow_trip_high),
        .trip_low(slow_trip_low)
    );

endmodule

`default_nettype wire

// ==== tb_adc_processing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_settings.svh"

module tb_adc_processing import adc_pkg::*; ();

    localparam int N_PASS = 200;
    localparam int N_AVG  = 160;
    localparam int N_SAT  = 120;
    localparam int N_BP   = 320;
    localparam int N_OVR  = 100;
    localparam int N_CMP  = 120;
    localparam int CYCLE_LIMIT =
        2 * (N_PASS + N_AVG + N_SAT + N_BP + N_OVR + 2 * N_CMP) + 200;
    localparam longint SAT_MAX = (64'sd1 <<< (`ADC_DATA_WIDTH - 1)) - 1;
    localparam longint SAT_MIN = -SAT_MAX - 1;

    logic    clock;
    logic    rst;
    sample_t in_data;
    logic    in_valid;
    shift_t  dec_shift;
    sample_t cal_offset;
    gain_t   cal_gain;
    sample_t fast_high;
    sample_t fast_low;
    sample_t slow_high;
    sample_t slow_low;
    logic    latch_mode;
    logic    clear_trips;
    logic    out_valid;
    sample_t out_data;
    logic    out_ready;
    logic    overrun;
    logic    fast_trip_high;
    logic    fast_trip_low;
    logic    slow_trip_high;
    logic    slow_trip_low;

    integer  seed;
    int      errors = 0;
    int      checks = 0;
    int      xfers = 0;
    int      cycle_count = 0;
    int      errors0;
    int      checks0;
    int      xfers0;
    int      sat_hits;
    bit      extreme = 1'b0;
    sample_t exp_q[$];
    sample_t exp_val;
    bit      have_exp;
    bit      armed = 1'b0;
    int      blk_sum;
    int      blk_cnt;
    int      cur_shift;
    sample_t cur_offset;
    gain_t   cur_gain;
    bit      m_fast_high = 1'b0;
    bit      m_fast_low = 1'b0;
    bit      m_slow_high = 1'b0;
    bit      m_slow_low = 1'b0;

    adc_processing adc_processing_inst (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic int rand_range(input int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    function automatic bit rand_pct(input int pct);
        return rand_range(100) < pct;
    endfunction

    // Extreme mode mixes full-scale values into the random stream
    function automatic sample_t next_sample();
        int pick;
        pick = rand_range(4);
        if (extreme && pick == 0) return sample_t'(SAT_MAX);
        if (extreme && pick == 1) return sample_t'(SAT_MIN);
        return sample_t'($random(seed));
    endfunction

    // Offset first, then Q4.12 gain with a floor shift, then clamp
    function automatic sample_t calibrate(input int avg);
        longint scaled;
        scaled = ((longint'(avg) - longint'(cur_offset)) * longint'(cur_gain))
                 >>> `ADC_GAIN_FRAC;
        if (scaled > SAT_MAX || scaled < SAT_MIN) sat_hits++;
        if (scaled > SAT_MAX) return sample_t'(SAT_MAX);
        if (scaled < SAT_MIN) return sample_t'(SAT_MIN);
        return sample_t'(scaled);
    endfunction

    task automatic model_sample(input sample_t s);
        blk_sum += int'(s);
        blk_cnt++;
        if (blk_cnt == (1 << cur_shift)) begin
            exp_q.push_back(calibrate(blk_sum >>> cur_shift));
            blk_sum = 0;
            blk_cnt = 0;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input bit want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic update_flags(input bit above, input bit below, inout bit hi, inout bit lo);
        if (latch_mode) begin
            hi = hi | above;
            lo = lo | below;
        end else begin
            hi = above;
            lo = below;
        end
    endtask

    // The scoreboard and comparator model step on the same edges as the DUT
    always @(posedge clock) begin
        have_exp = 1'b0;
        if (armed) begin
            check_flag("fast_trip_high", fast_trip_high, m_fast_high);
            check_flag("fast_trip_low", fast_trip_low, m_fast_low);
            check_flag("slow_trip_high", slow_trip_high, m_slow_high);
            check_flag("slow_trip_low", slow_trip_low, m_slow_low);
        end
        if (!rst && out_valid && out_ready) begin
            xfers++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output %h was sent while the model expected nothing", out_data);
            end else begin
                exp_val = exp_q.pop_front();
                have_exp = 1'b1;
                checks++;
                if (out_data !== exp_val) begin
                    errors++;
                    $display("Mismatch out_data: got %h expected %h", out_data, exp_val);
                end
            end
        end
        if (rst || clear_trips) begin
            m_fast_high = 1'b0;
            m_fast_low = 1'b0;
            m_slow_high = 1'b0;
            m_slow_low = 1'b0;
        end else begin
            if (in_valid) begin
                update_flags(in_data > fast_high, in_data < fast_low, m_fast_high, m_fast_low);
            end
            if (have_exp) begin
                update_flags(exp_val > slow_high, exp_val < slow_low, m_slow_high, m_slow_low);
            end
        end
        if (rst) armed = 1'b1;
    end

    task automatic start_test(input int shift, input int offset, input int gain);
        @(posedge clock);
        rst <= 1'b1;
        in_valid <= 1'b0;
        out_ready <= 1'b0;
        clear_trips <= 1'b0;
        dec_shift <= shift_t'(shift);
        cal_offset <= sample_t'(offset);
        cal_gain <= gain_t'(gain);
        cur_shift = shift;
        cur_offset = sample_t'(offset);
        cur_gain = gain_t'(gain);
        exp_q.delete();
        blk_sum = 0;
        blk_cnt = 0;
        sat_hits = 0;
        errors0 = errors;
        checks0 = checks;
        xfers0 = xfers;
        repeat (2) @(posedge clock);
        rst <= 1'b0;
    endtask

    task automatic drive_cycles(input int n, input int valid_pct, input int ready_pct,
                                input int clear_at);
        bit      v;
        sample_t d;
        for (int i = 0; i < n; i++) begin
            @(posedge clock);
            v = rand_pct(valid_pct);
            d = next_sample();
            in_valid <= v;
            in_data <= d;
            out_ready <= rand_pct(ready_pct);
            clear_trips <= (i == clear_at);
            if (v) model_sample(d);
        end
    endtask

    task automatic drain_queue(input int ready_pct);
        while (exp_q.size() != 0) begin
            @(posedge clock);
            in_valid <= 1'b0;
            clear_trips <= 1'b0;
            out_ready <= rand_pct(ready_pct);
        end
    endtask

    // Releases the sink and waits until the output has gone quiet
    task automatic wait_idle();
        int idle;
        idle = 0;
        while (idle < 4) begin
            @(posedge clock);
            in_valid <= 1'b0;
            out_ready <= 1'b1;
            @(negedge clock);
            idle = out_valid ? 0 : idle + 1;
        end
    endtask

    task automatic check_overrun(input bit want);
        @(negedge clock);
        checks++;
        if (overrun !== want) begin
            errors++;
            $display("Mismatch overrun: got %h expected %h", overrun, want);
        end
    endtask

    task automatic set_windows(input bit latch);
        latch_mode <= latch;
        fast_high <= sample_t'(rand_range(20000));
        fast_low <= sample_t'(-rand_range(20000));
        slow_high <= sample_t'(rand_range(20000));
        slow_low <= sample_t'(-rand_range(20000));
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d outputs, %0d checks, %0d errors", name, xfers - xfers0,
                 checks - checks0, errors - errors0);
    endtask

    initial begin
        seed = 32'hd7af;
        rst = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        dec_shift = '0;
        cal_offset = '0;
        cal_gain = 16'd4096;
        fast_high = 16'sd30000;
        fast_low = -16'sd30000;
        slow_high = 16'sd30000;
        slow_low = -16'sd30000;
        latch_mode = 1'b0;
        clear_trips = 1'b0;
        out_ready = 1'b0;

        start_test(0, 0, 4096);
        drive_cycles(N_PASS, 100, 100, -1);
        drain_queue(100);
        end_test("pass-through");

        start_test(2, rand_range(4096) - 2048, 2048 + rand_range(6144));
        drive_cycles(N_AVG, 80, 100, -1);
        drain_queue(100);
        end_test("averaging and calibration");

        // Gains near 16 push almost every block into the clamp
        extreme = 1'b1;
        start_test(1, rand_range(512) - 256, 16'hc000 + rand_range(16384));
        drive_cycles(N_SAT, 90, 100, -1);
        drain_queue(100);
        extreme = 1'b0;
        if (sat_hits == 0) begin
            errors++;
            $display("No sample reached the saturation limits in the saturation test");
        end
        end_test("saturation");

        start_test(3, rand_range(4096) - 2048, 3072 + rand_range(2048));
        drive_cycles(N_BP, 75, 50, -1);
        drain_queue(50);
        check_overrun(1'b0);
        end_test("back-pressure");

        // FIFO plus both calibrator stages bound how many blocks survive the stall
        start_test(0, 0, 4096);
        drive_cycles(N_OVR, 100, 0, -1);
        wait_idle();
        check_overrun(1'b1);
        if (xfers - xfers0 < 1 || xfers - xfers0 > `ADC_FIFO_DEPTH + 3) begin
            errors++;
            $display("Overrun test delivered %0d outputs, outside 1 to %0d",
                     xfers - xfers0, `ADC_FIFO_DEPTH + 3);
        end
        end_test("overrun");

        // The sink stalls now and then, so the slow window only sees real transfers
        start_test(1, 0, 4096);
        set_windows(1'b1);
        drive_cycles(N_CMP, 80, 80, N_CMP / 2);
        drain_queue(80);
        end_test("latching comparators");

        start_test(1, 0, 4096);
        set_windows(1'b0);
        drive_cycles(N_CMP, 80, 80, -1);
        drain_queue(80);
        end_test("live comparators");

        @(negedge clock);
        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
adc_pkg.sv
adc_decimator.sv
sample_fifo.sv
adc_calibrator.sv
window_comparator.sv
adc_processing.sv
tb_adc_processing.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_adc_processing
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
